//--- common/epu_param_params.svh
`ifndef EPU_PARAM_PARAMS_SVH
`define EPU_PARAM_PARAMS_SVH

// parameter SRAM geometry
`define PARAM_DEPTH 16
`define PARAM_AW    4
`define PARAM_DW    32

// engine datapath widths, both signed
`define SAMPLE_W    16
`define RESULT_W    32

// SRAM write request codes
`define WRITE_ENB   1'b1
`define WRITE_DIS   1'b0

`endif

//--- common/epu_param_pkg.sv
`include "epu_param_params.svh"

package epu_param_pkg;

  // host write strobe with its address and data
  typedef struct packed {
    logic                 wr;
    logic [`PARAM_AW-1:0] addr;
    logic [`PARAM_DW-1:0] data;
  } host_wr_t;

  // one access on the single SRAM port
  typedef struct packed {
    logic                 cs;
    logic                 we;
    logic [`PARAM_AW-1:0] addr;
    logic [`PARAM_DW-1:0] wdata;
  } sram_req_t;

  // word 0 layout
  typedef struct packed {
    logic [22:0]          rsvd;
    logic [4:0]           shift;
    logic [`PARAM_AW-1:0] num_ch;
  } param_hdr_t;

  // words 1..15 layout
  typedef struct packed {
    logic signed [15:0] scale;
    logic signed [15:0] bias;
  } param_coef_t;

  // header at address 0, coefficient everywhere else
  typedef union packed {
    param_hdr_t  hdr;
    param_coef_t coef;
  } param_word_u;

  typedef enum logic [2:0] {
    IDLE      = 3'h0,
    LOAD      = 3'h1,
    HDR_RD    = 3'h2,
    HDR_LATCH = 3'h3,
    RUN       = 3'h4
  } param_state_t;

endpackage

//--- epu_param.f
+incdir+common
common/epu_param_pkg.sv
param_buf/param_sram.sv
param_buf/param_buf_ctrl.sv
verilog/chan_index_cnt.sv
verilog/scale_bias_unit.sv
verilog/epu_param_top.sv
testbench/epu_param_clk_gen.sv
testbench/epu_param_props.sv
testbench/epu_param_tb.sv

//--- param_buf/param_buf_ctrl.sv
`timescale 1ns/10ps
`include "epu_param_params.svh"

module param_buf_ctrl (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enb_i,
  input  epu_param_pkg::host_wr_t  host_i,
  input  logic                     load_done_i,
  input  logic                     sample_valid_i,
  input  logic [`PARAM_AW-1:0]     chan_idx_i,
  output epu_param_pkg::sram_req_t sram_req_o,
  output logic                     hdr_latch_o,
  output logic                     sample_take_o,
  output logic                     cnt_restart_o,
  output logic                     ready_o
);

  import epu_param_pkg::*;

  param_state_t state_q;
  param_state_t state_d;
  logic         host_acc;
  logic         done_acc;

  // host writes are blocked while the header is being fetched
  assign host_acc = enb_i & host_i.wr & (state_q inside {IDLE, LOAD, RUN});
  assign done_acc = enb_i & load_done_i & (state_q == LOAD);

  assign ready_o       = (state_q == RUN);
  assign sample_take_o = sample_valid_i & ready_o;
  assign hdr_latch_o   = (state_q == HDR_LATCH);
  // counter restarts together with the header latch
  assign cnt_restart_o = (state_q == HDR_LATCH);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (host_acc) state_d = LOAD;
      end
      LOAD: begin
        if (done_acc) state_d = HDR_RD;
      end
      HDR_RD:    state_d = HDR_LATCH;
      HDR_LATCH: state_d = RUN;
      RUN: begin
        // any host write means new parameters are coming
        if (host_acc) state_d = LOAD;
      end
      default:   state_d = IDLE;
    endcase
  end

  // SRAM port mux
  always_comb begin
    sram_req_o    = '0;
    sram_req_o.we = `WRITE_DIS;
    if (host_acc) begin
      // write wins the port, a sample in the same cycle sees the last rdata
      sram_req_o.cs    = 1'b1;
      sram_req_o.we    = `WRITE_ENB;
      sram_req_o.addr  = host_i.addr;
      sram_req_o.wdata = host_i.data;
    end else if (state_q == HDR_RD) begin
      // header lives at address 0
      sram_req_o.cs   = 1'b1;
      sram_req_o.addr = '0;
    end else if (sample_take_o) begin
      sram_req_o.cs   = 1'b1;
      sram_req_o.addr = chan_idx_i;
    end
  end

endmodule

//--- param_buf/param_sram.sv
`timescale 1ns/10ps
`include "epu_param_params.svh"

module param_sram (
  input  logic                     clk,
  input  epu_param_pkg::sram_req_t req_i,
  output logic [`PARAM_DW-1:0]     rdata_o
);

  logic [`PARAM_DW-1:0] mem [0:`PARAM_DEPTH-1];

  // single port, one access per cycle
  always_ff @(posedge clk) begin
    if (req_i.cs) begin
      if (req_i.we == `WRITE_ENB) begin
        mem[req_i.addr] <= req_i.wdata;
      end else begin
        // read data holds until the next read
        rdata_o <= mem[req_i.addr];
      end
    end
  end

endmodule

//--- testbench/epu_param_clk_gen.sv
`timescale 1ns/10ps

module epu_param_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  // half period of 20 ns
  always begin
    #20 clk_o = ~clk_o;
  end

endmodule

//--- testbench/epu_param_props.sv
`timescale 1ns/10ps

module epu_param_props (
  input logic                        clk,
  input logic                        rst,
  input logic                        enb_i,
  input logic                        host_wr_i,
  input logic                        load_done_i,
  input logic                        sample_valid_i,
  input epu_param_pkg::param_state_t state_i,
  input logic                        ready_i,
  input logic                        out_valid_i
);

  import epu_param_pkg::*;

  logic sample_acc;
  logic done_acc;
  logic run_write;
  int   prop_err_cnt = 0;

  assign sample_acc = sample_valid_i & ready_i;
  assign done_acc   = enb_i & load_done_i & (state_i == LOAD);
  assign run_write  = enb_i & host_wr_i & ready_i;

  // coefficient read, then result register
  assert property (@(posedge clk) disable iff (rst) sample_acc |-> ##2 out_valid_i)
    else begin
      prop_err_cnt++;
      $error("out_valid_o missing two edges after an accepted sample");
    end

  assert property (@(posedge clk) disable iff (rst) out_valid_i |-> $past(sample_acc, 2))
    else begin
      prop_err_cnt++;
      $error("out_valid_o without an accepted sample two edges before");
    end

  // header read and header latch sit between load_done and RUN
  assert property (@(posedge clk) disable iff (rst)
    done_acc |-> ##1 !ready_i ##1 !ready_i ##1 ready_i)
    else begin
      prop_err_cnt++;
      $error("ready_o did not rise three edges after load_done_i");
    end

  assert property (@(posedge clk) disable iff (rst) run_write |=> !ready_i)
    else begin
      prop_err_cnt++;
      $error("ready_o stayed high after a host write in RUN");
    end

endmodule

bind epu_param_top epu_param_props epu_param_props_i (
  .clk            (clk),
  .rst            (rst),
  .enb_i          (enb_i),
  .host_wr_i      (host_i.wr),
  .load_done_i    (load_done_i),
  .sample_valid_i (sample_valid_i),
  .state_i        (param_buf_ctrl_i.state_q),
  .ready_i        (ready_o),
  .out_valid_i    (out_valid_o)
);

//--- testbench/epu_param_tb.sv
`timescale 1ns/10ps
`include "epu_param_params.svh"

module epu_param_tb;

  import epu_param_pkg::*;

  localparam int TIMEOUT = 40;

  logic                        clk;
  logic                        rst;
  logic                        enb;
  host_wr_t                    host;
  logic                        load_done;
  logic                        sample_valid;
  logic signed [`SAMPLE_W-1:0] sample;
  logic                        ready;
  logic                        out_valid;
  logic signed [`RESULT_W-1:0] result;

  // reference copy of the SRAM words and of the latched header
  logic [`PARAM_DW-1:0] mdl_mem [0:`PARAM_DEPTH-1];
  int                   mdl_num_ch;
  int                   mdl_shift;
  int                   mdl_idx;

  logic signed [`SAMPLE_W-1:0] smp_q[$];
  logic [`RESULT_W-1:0]        exp_q[$];
  logic [`RESULT_W-1:0]        got_q[$];
  int                          acc_cyc_q[$];
  int                          got_cyc_q[$];
  int                          cyc;
  logic [31:0]                 lcg_state;
  int                          err_cnt;
  int                          chk_cnt;
  int                          test_cnt;
  int                          fail_cnt;

  epu_param_clk_gen clk_gen_i (.clk_o(clk));

  epu_param_top epu_param_top_i (
    .clk            (clk),
    .rst            (rst),
    .enb_i          (enb),
    .host_i         (host),
    .load_done_i    (load_done),
    .sample_valid_i (sample_valid),
    .sample_i       (sample),
    .ready_o        (ready),
    .out_valid_o    (out_valid),
    .result_o       (result)
  );

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // results are collected mid-cycle
  always @(negedge clk) begin
    if (out_valid) begin
      got_q.push_back(result);
      got_cyc_q.push_back(cyc);
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [15:0] rand16();
    logic [31:0] r;
    r = lcg_next();
    return r[31:16];
  endfunction

  // floor division gives the same value as an arithmetic right shift
  function automatic logic [31:0] predict(input logic signed [15:0] smp,
                                          input logic [31:0] word, input int sh);
    longint prod;
    longint div;
    longint q;
    prod = longint'(smp) * longint'($signed(word[31:16]));
    div  = longint'(1) << sh;
    q    = prod / div;
    if (prod < 0 && (prod % div) != 0) begin
      q = q - 1;
    end
    return 32'(q + longint'($signed(word[15:0])));
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    chk_cnt++;
    assert (act_v === exp_v)
      else begin
        $display("CHECK FAILED %s: expected %08h, actual %08h", name, exp_v, act_v);
        err_cnt++;
      end
  endtask

  task automatic end_test(input string name, input int e0);
    test_cnt++;
    if (err_cnt == e0) begin
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt - e0);
    end
  endtask

  task automatic write_word(input logic [3:0] addr, input logic [31:0] data);
    host.wr   = 1'b1;
    host.addr = addr;
    host.data = data;
    if (enb) begin
      mdl_mem[addr] = data;
    end
    @(posedge clk);
    #2;
    host = '0;
  endtask

  task automatic finish_load(input string name);
    bit seen;
    load_done = 1'b1;
    if (enb) begin
      mdl_num_ch = mdl_mem[0][3:0];
      mdl_shift  = mdl_mem[0][8:4];
      mdl_idx    = 1;
    end
    @(posedge clk);
    #2;
    load_done = 1'b0;
    seen = 1'b0;
    for (int i = 0; i < TIMEOUT && !seen; i++) begin
      @(negedge clk);
      seen = ready;
    end
    if (!seen) begin
      $display("ERROR %s: ready_o did not rise after load_done_i", name);
      err_cnt++;
    end
    @(posedge clk);
    #2;
  endtask

  // random samples with their predicted results, channel walks 1..n
  task automatic queue_random(input int n);
    logic signed [15:0] s;
    repeat (n) begin
      s = rand16();
      smp_q.push_back(s);
      exp_q.push_back(predict(s, mdl_mem[mdl_idx], mdl_shift));
      if (mdl_idx >= mdl_num_ch) begin
        mdl_idx = 1;
      end else begin
        mdl_idx = mdl_idx + 1;
      end
    end
  endtask

  task automatic send_samples(input string name);
    int waited;
    got_q     = {};
    got_cyc_q = {};
    acc_cyc_q = {};
    foreach (smp_q[i]) begin
      sample_valid = 1'b1;
      sample       = smp_q[i];
      @(negedge clk);
      if (ready) begin
        acc_cyc_q.push_back(cyc);
      end else begin
        $display("ERROR %s: sample %0d was offered while ready_o was low", name, i);
        err_cnt++;
      end
      @(posedge clk);
      #2;
    end
    sample_valid = 1'b0;
    waited = 0;
    while (got_q.size() < exp_q.size() && waited < TIMEOUT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (got_q.size() != exp_q.size()) begin
      $display("ERROR %s: timed out with %0d of %0d results", name, got_q.size(), exp_q.size());
      err_cnt++;
    end
    foreach (got_q[i]) begin
      if (i < exp_q.size() && i < acc_cyc_q.size()) begin
        check_val(name, exp_q[i], got_q[i]);
        check_val({name, " latency"}, 32'd2, 32'(got_cyc_q[i] - acc_cyc_q[i]));
      end
    end
    smp_q = {};
    exp_q = {};
  endtask

  task automatic test_reset_idle();
    int e0;
    e0 = err_cnt;
    check_val("reset ready_o", 32'd0, 32'(ready));
    check_val("reset out_valid_o", 32'd0, 32'(out_valid));
    got_q = {};
    sample_valid = 1'b1;
    repeat (6) begin
      sample = rand16();
      @(posedge clk);
      #2;
    end
    sample_valid = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    check_val("idle ready_o", 32'd0, 32'(ready));
    check_val("idle result count", 32'd0, 32'(got_q.size()));
    end_test("reset_idle", e0);
  endtask

  task automatic test_basic_load();
    int e0;
    e0 = err_cnt;
    write_word(4'd0, {23'd0, 5'd2, 4'd3});
    write_word(4'd1, {16'd3, 16'd10});
    write_word(4'd2, {16'hfffb, 16'd7});
    write_word(4'd3, {16'd2, 16'hffec});
    finish_load("basic_load");
    // one sample at a time so each latency stands alone
    repeat (3) begin
      queue_random(1);
      send_samples("basic_load");
    end
    end_test("basic_load", e0);
  endtask

  task automatic test_channel_order();
    int ch [7] = '{1, 2, 3, 1, 2, 3, 1};
    int e0;
    e0 = err_cnt;
    foreach (ch[i]) begin
      smp_q.push_back(rand16());
      exp_q.push_back(predict(smp_q[i], mdl_mem[ch[i]], mdl_shift));
    end
    mdl_idx = 2;
    send_samples("channel_order");
    end_test("channel_order", e0);
  endtask

  task automatic test_reload();
    int e0;
    e0 = err_cnt;
    write_word(4'd1, {16'd1, 16'd0});
    check_val("reload ready_o", 32'd0, 32'(ready));
    got_q = {};
    sample_valid = 1'b1;
    repeat (3) begin
      sample = rand16();
      @(posedge clk);
      #2;
    end
    sample_valid = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    check_val("reload blocked result count", 32'd0, 32'(got_q.size()));
    write_word(4'd2, {16'hfff0, 16'd300});
    write_word(4'd3, {16'd7, 16'hff38});
    finish_load("reload");
    queue_random(6);
    send_samples("reload");
    end_test("reload", e0);
  endtask

  task automatic test_enb_low();
    int e0;
    e0 = err_cnt;
    enb = 1'b0;
    write_word(4'd1, 32'h7fff_7fff);
    check_val("enb_low write ready_o", 32'd1, 32'(ready));
    // back to LOAD with the same header, then a disabled write and load_done
    enb = 1'b1;
    write_word(4'd0, mdl_mem[0]);
    enb = 1'b0;
    write_word(4'd2, 32'h7fff_7fff);
    load_done = 1'b1;
    @(posedge clk);
    #2;
    load_done = 1'b0;
    repeat (4) @(posedge clk);
    #2;
    check_val("enb_low load_done ready_o", 32'd0, 32'(ready));
    enb = 1'b1;
    finish_load("enb_low");
    queue_random(4);
    send_samples("enb_low");
    end_test("enb_low", e0);
  endtask

  task automatic test_random();
    int          e0;
    logic [15:0] sh;
    logic [31:0] w;
    e0 = err_cnt;
    sh = rand16();
    write_word(4'd0, {23'd0, sh[4:0], 4'd15});
    for (int a = 1; a < 16; a++) begin
      w = {rand16(), rand16()};
      // channel 1 always carries a negative scale and bias
      if (a == 1) begin
        w = w | 32'h8000_8000;
      end
      write_word(4'(a), w);
    end
    finish_load("random");
    queue_random(40);
    send_samples("random");
    end_test("random", e0);
  endtask

  initial begin
    lcg_state    = 32'h7ffdb65c;
    err_cnt      = 0;
    chk_cnt      = 0;
    test_cnt     = 0;
    fail_cnt     = 0;
    rst          = 1'b1;
    enb          = 1'b1;
    host         = '0;
    load_done    = 1'b0;
    sample_valid = 1'b0;
    sample       = '0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;
    test_reset_idle();
    test_basic_load();
    test_channel_order();
    test_reload();
    test_enb_low();
    test_random();
    // bound property failures count as errors too
    err_cnt = err_cnt + epu_param_top_i.epu_param_props_i.prop_err_cnt;
    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             test_cnt, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- verilog/chan_index_cnt.sv
`timescale 1ns/10ps
`include "epu_param_params.svh"

module chan_index_cnt (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 restart_i,
  input  logic                 step_i,
  input  logic [`PARAM_AW-1:0] num_ch_i,
  output logic [`PARAM_AW-1:0] idx_o
);

  logic [`PARAM_AW-1:0] idx_q;
  logic                 at_last;

  // a count of 0 acts like 1 since idx never drops below 1
  assign at_last = (idx_q >= num_ch_i);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      idx_q <= `PARAM_AW'(1);
    end else if (restart_i) begin
      idx_q <= `PARAM_AW'(1);
    end else if (step_i) begin
      if (at_last) begin
        idx_q <= `PARAM_AW'(1);
      end else begin
        idx_q <= idx_q + `PARAM_AW'(1);
      end
    end
  end

  assign idx_o = idx_q;

endmodule

//--- verilog/epu_param_top.sv
`timescale 1ns/10ps
`include "epu_param_params.svh"

module epu_param_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        enb_i,
  input  epu_param_pkg::host_wr_t     host_i,
  input  logic                        load_done_i,
  input  logic                        sample_valid_i,
  input  logic signed [`SAMPLE_W-1:0] sample_i,
  output logic                        ready_o,
  output logic                        out_valid_o,
  output logic signed [`RESULT_W-1:0] result_o
);

  import epu_param_pkg::*;

  sram_req_t            sram_req;
  param_word_u          sram_rdata;
  logic                 hdr_latch;
  logic                 sample_take;
  logic                 cnt_restart;
  logic [`PARAM_AW-1:0] chan_idx;
  logic [`PARAM_AW-1:0] num_ch;

  param_buf_ctrl param_buf_ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .enb_i          (enb_i),
    .host_i         (host_i),
    .load_done_i    (load_done_i),
    .sample_valid_i (sample_valid_i),
    .chan_idx_i     (chan_idx),
    .sram_req_o     (sram_req),
    .hdr_latch_o    (hdr_latch),
    .sample_take_o  (sample_take),
    .cnt_restart_o  (cnt_restart),
    .ready_o        (ready_o)
  );

  param_sram param_sram_i (
    .clk     (clk),
    .req_i   (sram_req),
    .rdata_o (sram_rdata)
  );

  // index advances on every accepted sample
  chan_index_cnt chan_index_cnt_i (
    .clk       (clk),
    .rst       (rst),
    .restart_i (cnt_restart),
    .step_i    (sample_take),
    .num_ch_i  (num_ch),
    .idx_o     (chan_idx)
  );

  scale_bias_unit scale_bias_unit_i (
    .clk           (clk),
    .rst           (rst),
    .hdr_latch_i   (hdr_latch),
    .sample_take_i (sample_take),
    .sample_i      (sample_i),
    .rdata_i       (sram_rdata),
    .num_ch_o      (num_ch),
    .out_valid_o   (out_valid_o),
    .result_o      (result_o)
  );

endmodule

//--- verilog/scale_bias_unit.sv
`timescale 1ns/10ps
`include "epu_param_params.svh"

module scale_bias_unit (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          hdr_latch_i,
  input  logic                          sample_take_i,
  input  logic signed [`SAMPLE_W-1:0]   sample_i,
  input  epu_param_pkg::param_word_u    rdata_i,
  output logic [`PARAM_AW-1:0]          num_ch_o,
  output logic                          out_valid_o,
  output logic signed [`RESULT_W-1:0]   result_o
);

  import epu_param_pkg::*;

  param_coef_t                 coef;
  logic [`PARAM_AW-1:0]        num_ch_q;
  logic [4:0]                  shift_q;
  logic signed [`SAMPLE_W-1:0] s1_sample;
  logic                        s1_valid;
  logic signed [`RESULT_W-1:0] product;
  logic signed [`RESULT_W-1:0] shifted;
  logic signed [`RESULT_W-1:0] bias_ext;
  logic signed [`RESULT_W-1:0] sum;

  // header fields, captured once per load
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      num_ch_q <= '0;
      shift_q  <= '0;
    end else if (hdr_latch_i) begin
      num_ch_q <= rdata_i.hdr.num_ch;
      shift_q  <= rdata_i.hdr.shift;
    end
  end

  assign num_ch_o = num_ch_q;

  // stage 1, sample waits for its coefficient read
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= sample_take_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sample_take_i) begin
      s1_sample <= sample_i;
    end
  end

  // stage 2 arithmetic
  assign coef     = rdata_i.coef;
  assign product  = $signed(s1_sample) * $signed(coef.scale);
  assign shifted  = product >>> shift_q;
  assign bias_ext = $signed(coef.bias);
  assign sum      = shifted + bias_ext;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      result_o <= sum;
    end
  end

endmodule
